//--- Bender.yml
package:
  name: obi_mem_subsys

sources:
  - files:
      - src/obi_pkg.sv
      - src/subsys_pkg.sv
      - src/core_cntrl_regs.sv
      - src/instr_fetch.sv
      - src/obi_integrity.sv
      - src/obi_sram.sv
      - src/obi_mem_subsys.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_obi_mem_subsys.sv

//--- flist.f
src/obi_pkg.sv
src/subsys_pkg.sv
src/core_cntrl_regs.sv
src/instr_fetch.sv
src/obi_integrity.sv
src/obi_sram.sv
src/obi_mem_subsys.sv
sim/tb_clk_gen.sv
sim/tb_obi_mem_subsys.sv

//--- sim/tb_clk_gen.sv
//--------------------------------------------------------------------------
// Testbench clock and active-low reset generator
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_n_o
);

    // Free-running clock, 50 percent duty
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset held low for a fixed number of rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule : tb_clk_gen

//--- sim/tb_obi_mem_subsys.sv
//--------------------------------------------------------------------------
// Directed tests of the OBI memory subsystem with a shadow memory model
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module tb_obi_mem_subsys
    import obi_pkg::*;
    import subsys_pkg::*;
();

    localparam int MEM_DEPTH   = 1024;
    localparam int WAIT_LIMIT  = 50;
    localparam int FETCH_LIMIT = 400;

    logic      clk;
    logic      rst_n;
    logic      cfg_we_i;
    cfg_addr_t cfg_addr_i;
    data_t     cfg_wdata_i;
    data_t     cfg_rdata_o;
    logic      data_req_i;
    logic      data_reqpar_i;
    logic      data_we_i;
    be_t       data_be_i;
    addr_t     data_addr_i;
    data_t     data_wdata_i;
    logic      data_gnt_o;
    logic      data_gntpar_o;
    logic      data_rvalid_o;
    logic      data_rvalidpar_o;
    data_t     data_rdata_o;
    logic      fetch_valid_o;
    addr_t     fetch_addr_o;
    data_t     fetch_rdata_o;
    logic      fetch_idle_o;
    logic      alert_major_o;
    hartid_t   mhartid_o;

    // Expected memory contents and fetch stream state
    data_t     shadow [MEM_DEPTH];
    addr_t     exp_fetch_addr;
    int        fetch_count;
    string     test_name;

    tb_clk_gen #(.PERIOD_NS(100), .RST_CYCLES(8)) u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    obi_mem_subsys uut (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .cfg_we_i         (cfg_we_i),
        .cfg_addr_i       (cfg_addr_i),
        .cfg_wdata_i      (cfg_wdata_i),
        .cfg_rdata_o      (cfg_rdata_o),
        .data_req_i       (data_req_i),
        .data_reqpar_i    (data_reqpar_i),
        .data_we_i        (data_we_i),
        .data_be_i        (data_be_i),
        .data_addr_i      (data_addr_i),
        .data_wdata_i     (data_wdata_i),
        .data_gnt_o       (data_gnt_o),
        .data_gntpar_o    (data_gntpar_o),
        .data_rvalid_o    (data_rvalid_o),
        .data_rvalidpar_o (data_rvalidpar_o),
        .data_rdata_o     (data_rdata_o),
        .fetch_valid_o    (fetch_valid_o),
        .fetch_addr_o     (fetch_addr_o),
        .fetch_rdata_o    (fetch_rdata_o),
        .fetch_idle_o     (fetch_idle_o),
        .alert_major_o    (alert_major_o),
        .mhartid_o        (mhartid_o)
    );

    // ------------------------------------------------------------------------
    // Failure reporting and helpers
    // ------------------------------------------------------------------------

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR test %s, %s: expected %h, actual %h",
                     test_name, what, expected, actual);
            abort_run("value mismatch");
        end
    endtask

    // Byte-lane merge as a byte-enabled write sees it
    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input be_t be);
        data_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // Word index with wrap at the memory depth
    function automatic int word_index(input addr_t addr);
        return (addr >> 2) % MEM_DEPTH;
    endfunction

    // ------------------------------------------------------------------------
    // Bus tasks entered just after a rising edge
    // ------------------------------------------------------------------------

    task automatic cfg_write(input cfg_addr_t addr, input data_t wdata);
        cfg_we_i    <= 1'b1;
        cfg_addr_i  <= addr;
        cfg_wdata_i <= wdata;
        @(posedge clk);
        cfg_we_i    <= 1'b0;
    endtask

    task automatic cfg_read(input cfg_addr_t addr, output data_t rdata);
        cfg_addr_i <= addr;
        @(posedge clk);
        rdata = cfg_rdata_o;
    endtask

    // One OBI data transfer with good parity and timed grant and response
    task automatic data_access(input logic we, input be_t be, input addr_t addr,
                               input data_t wdata, output data_t rdata);
        int n;
        data_req_i    <= 1'b1;
        data_reqpar_i <= 1'b0;
        data_we_i     <= we;
        data_be_i     <= be;
        data_addr_i   <= addr;
        data_wdata_i  <= wdata;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                abort_run("timed out waiting for data_gnt_o");
            end
        end while (data_gnt_o !== 1'b1);
        check_value("gnt latency", 1, n);
        data_req_i    <= 1'b0;
        data_reqpar_i <= 1'b1;
        data_we_i     <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                abort_run("timed out waiting for data_rvalid_o");
            end
        end while (data_rvalid_o !== 1'b1);
        check_value("rvalid latency", 1, n);
        rdata = data_rdata_o;
    endtask

    task automatic data_write(input addr_t addr, input data_t wdata, input be_t be,
                              input bit check_old);
        data_t old_word;
        int    idx;
        idx = word_index(addr);
        data_access(1'b1, be, addr, wdata, old_word);
        // Write response carries the word before the write
        if (check_old) begin
            check_value("old word", shadow[idx], old_word);
        end
        shadow[idx] = merge_bytes(shadow[idx], wdata, be);
    endtask

    task automatic data_read_check(input addr_t addr);
        data_t rdata;
        data_access(1'b0, 4'h0, addr, '0, rdata);
        check_value("read data", shadow[word_index(addr)], rdata);
    endtask

    task automatic wait_fetch_count(input int target);
        int n;
        n = 0;
        while (fetch_count < target) begin
            @(posedge clk);
            n++;
            if (n > FETCH_LIMIT) begin
                abort_run("timed out waiting for fetch_valid_o strobes");
            end
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (fetch_idle_o !== 1'b1) begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                abort_run("timed out waiting for fetch_idle_o after disable");
            end
        end
    endtask

    // Fetch start from a given boot address
    task automatic start_fetch(input addr_t boot);
        cfg_write(REG_BOOT_ADDR, boot);
        exp_fetch_addr = boot;
        fetch_count    = 0;
        cfg_write(REG_FETCH_EN, 32'h1);
    endtask

    // ------------------------------------------------------------------------
    // Monitors
    // ------------------------------------------------------------------------

    // Response parity is the inverse of the strobe in every cycle
    always @(posedge clk) begin
        if (rst_n === 1'b1) begin
            check_value("gntpar", !data_gnt_o, data_gntpar_o);
            check_value("rvalidpar", !data_rvalid_o, data_rvalidpar_o);
        end
    end

    // Fetch stream must be sequential and match memory
    always @(posedge clk) begin
        if ((rst_n === 1'b1) && (fetch_valid_o === 1'b1)) begin
            check_value("fetch addr", exp_fetch_addr, fetch_addr_o);
            check_value("fetch data", shadow[word_index(exp_fetch_addr)], fetch_rdata_o);
            exp_fetch_addr = exp_fetch_addr + 32'd4;
            fetch_count    = fetch_count + 1;
        end
    end

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------

    task automatic test_reset_values();
        data_t   rdata;
        hartid_t hart;
        test_name = "reset_values";
        check_value("fetch_idle_o", 1, fetch_idle_o);
        check_value("alert_major_o", 0, alert_major_o);
        check_value("fetch_valid_o", 0, fetch_valid_o);
        check_value("data_gnt_o", 0, data_gnt_o);
        check_value("data_rvalid_o", 0, data_rvalid_o);
        cfg_read(REG_BOOT_ADDR, rdata);
        check_value("boot addr reset", BOOT_ADDR_RST, rdata);
        cfg_read(REG_FETCH_EN, rdata);
        check_value("fetch en reset", 0, rdata);
        cfg_read(REG_MHARTID, rdata);
        check_value("hart id reset", 0, rdata);
        cfg_read(REG_ALERT, rdata);
        check_value("alert reset", 0, rdata);
        // Readback of written values
        hart = $urandom;
        cfg_write(REG_MHARTID, hart);
        cfg_read(REG_MHARTID, rdata);
        check_value("hart id readback", hart, rdata);
        check_value("mhartid_o", hart, mhartid_o);
        cfg_write(REG_BOOT_ADDR, 32'h0000_0100);
        cfg_read(REG_BOOT_ADDR, rdata);
        check_value("boot addr readback", 32'h0000_0100, rdata);
    endtask

    task automatic test_data_port();
        addr_t addrs [16];
        test_name = "data_port";
        // Full words first so every later byte merge has a known base
        for (int i = 0; i < 16; i++) begin
            addrs[i] = {$urandom} & 32'hffff_fffc;
            data_write(addrs[i], $urandom, 4'hf, 1'b0);
        end
        for (int i = 0; i < 16; i++) begin
            data_write(addrs[i], $urandom, be_t'($urandom % 16), 1'b1);
        end
        for (int i = 0; i < 16; i++) begin
            data_read_check(addrs[i]);
        end
    endtask

    task automatic test_fetch_stream();
        test_name = "fetch_stream";
        for (int i = 0; i < MEM_DEPTH; i++) begin
            data_write(addr_t'(i * 4), $urandom, 4'hf, 1'b0);
        end
        start_fetch(addr_t'(($urandom % MEM_DEPTH) * 4));
        wait_fetch_count(32);
    endtask

    // Fetch keeps running from the previous test
    task automatic test_arbitration();
        int start_count;
        test_name   = "arbitration";
        start_count = fetch_count;
        for (int i = 0; i < 24; i++) begin
            data_read_check({$urandom} & 32'hffff_fffc);
        end
        wait_fetch_count(start_count + 8);
    endtask

    task automatic test_integrity();
        data_t rdata;
        test_name = "integrity";
        // reqpar equal to req is a parity error
        data_req_i    <= 1'b1;
        data_reqpar_i <= 1'b1;
        data_we_i     <= 1'b0;
        data_addr_i   <= 32'h0000_0040;
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            check_value("gnt on bad parity", 0, data_gnt_o);
        end
        data_req_i <= 1'b0;
        @(posedge clk);
        check_value("alert_major_o set", 1, alert_major_o);
        cfg_read(REG_ALERT, rdata);
        check_value("alert reg set", 1, rdata);
        cfg_write(REG_ALERT, 32'h1);
        cfg_read(REG_ALERT, rdata);
        check_value("alert reg cleared", 0, rdata);
        check_value("alert_major_o cleared", 0, alert_major_o);
        data_read_check(32'h0000_0040);
    endtask

    task automatic test_stop_restart();
        addr_t boot;
        test_name = "stop_restart";
        cfg_write(REG_FETCH_EN, 32'h0);
        wait_idle();
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            check_value("fetch_valid_o while idle", 0, fetch_valid_o);
        end
        boot = addr_t'(($urandom % MEM_DEPTH) * 4);
        start_fetch(boot);
        wait_fetch_count(8);
        cfg_write(REG_FETCH_EN, 32'h0);
        wait_idle();
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        int n;
        cfg_we_i       = 1'b0;
        cfg_addr_i     = '0;
        cfg_wdata_i    = '0;
        data_req_i     = 1'b0;
        data_reqpar_i  = 1'b1;
        data_we_i      = 1'b0;
        data_be_i      = '0;
        data_addr_i    = '0;
        data_wdata_i   = '0;
        exp_fetch_addr = '0;
        fetch_count    = 0;
        test_name      = "startup";
        void'($urandom(32'hc2c7));

        n = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                abort_run("reset was never released");
            end
        end
        @(posedge clk);

        test_reset_values();
        test_data_port();
        test_fetch_stream();
        test_arbitration();
        test_integrity();
        test_stop_restart();

        $display("STATUS: PASS");
        $finish;
    end

endmodule : tb_obi_mem_subsys

//--- src/core_cntrl_regs.sv
//--------------------------------------------------------------------------
// Control and status registers: boot address, fetch enable, hart id, alert
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module core_cntrl_regs
    import obi_pkg::*;
    import subsys_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,

    // Configuration port
    input  logic      cfg_we_i,
    input  cfg_addr_t cfg_addr_i,
    input  data_t     cfg_wdata_i,
    output data_t     cfg_rdata_o,

    // Alert status from the integrity checker
    input  logic      alert_major_i,

    // Register outputs
    output addr_t     boot_addr_o,
    output logic      fetch_en_o,
    output hartid_t   mhartid_o,
    output logic      alert_clr_o
);

    addr_t   boot_addr_q;
    logic    fetch_en_q;
    hartid_t mhartid_q;

    // Write decode, takes effect on the next edge
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            boot_addr_q <= BOOT_ADDR_RST;
            fetch_en_q  <= FETCH_EN_RST;
            mhartid_q   <= MHARTID_RST;
        end else if (cfg_we_i) begin
            case (cfg_reg_e'(cfg_addr_i))
                REG_BOOT_ADDR: boot_addr_q <= cfg_wdata_i;
                REG_FETCH_EN:  fetch_en_q  <= cfg_wdata_i[0];
                REG_MHARTID:   mhartid_q   <= cfg_wdata_i;
                // Alert register has no storage here, see clear pulse
                default: ;
            endcase
        end
    end

    // Write-one-to-clear on alert bit 0
    // Lasts as long as the write strobe, one cycle per write
    assign alert_clr_o = cfg_we_i && (cfg_reg_e'(cfg_addr_i) == REG_ALERT) && cfg_wdata_i[0];

    // Read mux follows the address with no register stage
    always_comb begin
        cfg_rdata_o = '0;
        case (cfg_reg_e'(cfg_addr_i))
            REG_BOOT_ADDR: cfg_rdata_o = boot_addr_q;
            REG_FETCH_EN:  cfg_rdata_o = {31'b0, fetch_en_q};
            REG_MHARTID:   cfg_rdata_o = mhartid_q;
            REG_ALERT:     cfg_rdata_o = {31'b0, alert_major_i};
            default:       cfg_rdata_o = '0;
        endcase
    end

    assign boot_addr_o = boot_addr_q;
    assign fetch_en_o  = fetch_en_q;
    assign mhartid_o   = mhartid_q;

endmodule : core_cntrl_regs

//--- src/instr_fetch.sv
//--------------------------------------------------------------------------
// OBI instruction fetch requester with a bounded number of reads in flight
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module instr_fetch
    import obi_pkg::*;
    import subsys_pkg::*;
#(
    parameter int MAX_OUTSTANDING = 2
) (
    input  logic  clk_i,
    input  logic  rst_n_i,

    // Control
    input  logic  fetch_en_i,
    input  addr_t boot_addr_i,

    // OBI instruction requester, read only
    output logic  instr_req_o,
    output addr_t instr_addr_o,
    input  logic  instr_gnt_i,
    input  logic  instr_rvalid_i,
    input  data_t instr_rdata_i,

    // Fetched instruction stream, never stalled
    output logic  fetch_valid_o,
    output addr_t fetch_addr_o,
    output data_t fetch_rdata_o,
    output logic  fetch_idle_o
);

    localparam int PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
    localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

    fetch_state_e     state_q;
    fetch_state_e     state_d;
    addr_t            next_addr_q;
    logic [CNT_W-1:0] out_cnt_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic             req_granted;

    // Addresses of granted reads, oldest at rd_ptr_q
    addr_t            addr_fifo [MAX_OUTSTANDING];

    // Pointer step with wrap at the FIFO depth
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(MAX_OUTSTANDING - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // ------------------------------------------------------------------------
    // Request side
    // ------------------------------------------------------------------------

    // No new request once enable drops, even if one was pending
    assign instr_req_o  = (state_q == RUN) && fetch_en_i &&
                          (out_cnt_q < CNT_W'(MAX_OUTSTANDING));
    assign instr_addr_o = next_addr_q;
    assign req_granted  = instr_req_o && instr_gnt_i;

    // FSM next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (fetch_en_i) begin
                    state_d = RUN;
                end
            end
            RUN: begin
                if (!fetch_en_i) begin
                    state_d = DRAIN;
                end
            end
            DRAIN: begin
                // Wait until every granted read has come back
                if (out_cnt_q == '0) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            next_addr_q <= '0;
            out_cnt_q   <= '0;
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
        end else begin
            state_q <= state_d;
            // Every start from IDLE reloads the boot address
            if ((state_q == IDLE) && fetch_en_i) begin
                next_addr_q <= boot_addr_i;
            end else if (req_granted) begin
                next_addr_q <= next_addr_q + addr_t'(4);
            end
            // Outstanding count, grant in and response out
            case ({req_granted, instr_rvalid_i})
                2'b10:   out_cnt_q <= out_cnt_q + 1'b1;
                2'b01:   out_cnt_q <= out_cnt_q - 1'b1;
                default: ;
            endcase
            if (req_granted) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (instr_rvalid_i) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_granted) begin
            addr_fifo[wr_ptr_q] <= next_addr_q;
        end
    end

    // ------------------------------------------------------------------------
    // Response side
    // ------------------------------------------------------------------------

    // Responses arrive in order, so the FIFO head is the matching address
    assign fetch_valid_o = instr_rvalid_i;
    assign fetch_addr_o  = addr_fifo[rd_ptr_q];
    assign fetch_rdata_o = instr_rdata_i;
    assign fetch_idle_o  = (state_q == IDLE);

endmodule : instr_fetch

//--- src/obi_integrity.sv
//--------------------------------------------------------------------------
// Data port parity check, request gating, sticky alert and response parity
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module obi_integrity
    import subsys_pkg::*;
(
    input  logic clk_i,
    input  logic rst_n_i,

    // Request and its inverted copy from the external master
    input  logic data_req_i,
    input  logic data_reqpar_i,

    // Response strobes from the memory
    input  logic data_gnt_i,
    input  logic data_rvalid_i,

    // Clear pulse from the register block
    input  logic alert_clr_i,

    output logic req_ok_o,
    output logic data_gntpar_o,
    output logic data_rvalidpar_o,
    output logic alert_major_o
);

    logic par_err;
    logic alert_q;

    // reqpar must always be the inverse of req
    // A mismatch on either line is an error, even with req low
    assign par_err = (data_reqpar_i == data_req_i);

    // Memory only sees requests whose parity checks out
    assign req_ok_o = data_req_i && !par_err;

    // Sticky alert, a new error wins over a clear in the same cycle
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            alert_q <= ALERT_RST;
        end else if (par_err) begin
            alert_q <= 1'b1;
        end else if (alert_clr_i) begin
            alert_q <= 1'b0;
        end
    end

    assign alert_major_o = alert_q;

    // Inverted copies of the response strobes
    assign data_gntpar_o    = ~data_gnt_i;
    assign data_rvalidpar_o = ~data_rvalid_i;

endmodule : obi_integrity

//--- src/obi_mem_subsys.sv
//--------------------------------------------------------------------------
// Memory subsystem top: control registers, fetch, integrity and SRAM
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module obi_mem_subsys
    import obi_pkg::*;
    import subsys_pkg::*;
#(
    parameter int MEM_DEPTH_WORDS = 1024,
    parameter int MAX_OUTSTANDING = 2
) (
    input  logic      clk_i,
    input  logic      rst_n_i,

    // Configuration port
    input  logic      cfg_we_i,
    input  cfg_addr_t cfg_addr_i,
    input  data_t     cfg_wdata_i,
    output data_t     cfg_rdata_o,

    // External data OBI port with parity
    input  logic      data_req_i,
    input  logic      data_reqpar_i,
    input  logic      data_we_i,
    input  be_t       data_be_i,
    input  addr_t     data_addr_i,
    input  data_t     data_wdata_i,
    output logic      data_gnt_o,
    output logic      data_gntpar_o,
    output logic      data_rvalid_o,
    output logic      data_rvalidpar_o,
    output data_t     data_rdata_o,

    // Fetched instruction stream
    output logic      fetch_valid_o,
    output addr_t     fetch_addr_o,
    output data_t     fetch_rdata_o,
    output logic      fetch_idle_o,

    // Status toward the surrounding core
    output logic      alert_major_o,
    output hartid_t   mhartid_o
);

    // Register block outputs
    addr_t boot_addr;
    logic  fetch_en;
    logic  alert_clr;

    // Parity-checked data request
    logic  req_ok;

    // Internal instruction OBI port
    logic  instr_req;
    addr_t instr_addr;
    logic  instr_gnt;
    logic  instr_rvalid;
    data_t instr_rdata;

    core_cntrl_regs u_regs (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .cfg_we_i      (cfg_we_i),
        .cfg_addr_i    (cfg_addr_i),
        .cfg_wdata_i   (cfg_wdata_i),
        .cfg_rdata_o   (cfg_rdata_o),
        .alert_major_i (alert_major_o),
        .boot_addr_o   (boot_addr),
        .fetch_en_o    (fetch_en),
        .mhartid_o     (mhartid_o),
        .alert_clr_o   (alert_clr)
    );

    instr_fetch #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) u_fetch (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .fetch_en_i     (fetch_en),
        .boot_addr_i    (boot_addr),
        .instr_req_o    (instr_req),
        .instr_addr_o   (instr_addr),
        .instr_gnt_i    (instr_gnt),
        .instr_rvalid_i (instr_rvalid),
        .instr_rdata_i  (instr_rdata),
        .fetch_valid_o  (fetch_valid_o),
        .fetch_addr_o   (fetch_addr_o),
        .fetch_rdata_o  (fetch_rdata_o),
        .fetch_idle_o   (fetch_idle_o)
    );

    // Parity check sits between the external port and the memory
    obi_integrity u_integrity (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .data_req_i       (data_req_i),
        .data_reqpar_i    (data_reqpar_i),
        .data_gnt_i       (data_gnt_o),
        .data_rvalid_i    (data_rvalid_o),
        .alert_clr_i      (alert_clr),
        .req_ok_o         (req_ok),
        .data_gntpar_o    (data_gntpar_o),
        .data_rvalidpar_o (data_rvalidpar_o),
        .alert_major_o    (alert_major_o)
    );

    obi_sram #(
        .MEM_DEPTH_WORDS (MEM_DEPTH_WORDS)
    ) u_sram (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .d_req_i    (req_ok),
        .d_we_i     (data_we_i),
        .d_be_i     (data_be_i),
        .d_addr_i   (data_addr_i),
        .d_wdata_i  (data_wdata_i),
        .d_gnt_o    (data_gnt_o),
        .d_rvalid_o (data_rvalid_o),
        .d_rdata_o  (data_rdata_o),
        .i_req_i    (instr_req),
        .i_addr_i   (instr_addr),
        .i_gnt_o    (instr_gnt),
        .i_rvalid_o (instr_rvalid),
        .i_rdata_o  (instr_rdata)
    );

endmodule : obi_mem_subsys

//--- src/obi_pkg.sv
//--------------------------------------------------------------------------
// Vector types shared by the OBI data and instruction ports
//--------------------------------------------------------------------------

package obi_pkg;

    // Byte address as seen on the bus
    typedef logic [31:0] addr_t;

    // One bus word, read or write payload
    typedef logic [31:0] data_t;

    // Byte enables, one per byte lane of data_t
    typedef logic [3:0] be_t;

    // Hart id handed to the surrounding core
    typedef logic [31:0] hartid_t;

endpackage : obi_pkg

//--- src/obi_sram.sv
//--------------------------------------------------------------------------
// Single-port word memory shared by data and instruction OBI ports
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module obi_sram
    import obi_pkg::*;
#(
    parameter int MEM_DEPTH_WORDS = 1024
) (
    input  logic  clk_i,
    input  logic  rst_n_i,

    // Data port, already checked for integrity
    input  logic  d_req_i,
    input  logic  d_we_i,
    input  be_t   d_be_i,
    input  addr_t d_addr_i,
    input  data_t d_wdata_i,
    output logic  d_gnt_o,
    output logic  d_rvalid_o,
    output data_t d_rdata_o,

    // Instruction port, read only
    input  logic  i_req_i,
    input  addr_t i_addr_i,
    output logic  i_gnt_o,
    output logic  i_rvalid_o,
    output data_t i_rdata_o
);

    localparam int IDX_W = $clog2(MEM_DEPTH_WORDS);

    data_t            mem [MEM_DEPTH_WORDS];
    logic [IDX_W-1:0] d_idx;
    logic [IDX_W-1:0] i_idx;
    logic [IDX_W-1:0] acc_idx;
    data_t            rd_word;
    data_t            d_rdata_q;
    data_t            i_rdata_q;
    logic             d_rvalid_q;
    logic             i_rvalid_q;

    // Word index, upper address bits wrap around the depth
    assign d_idx = d_addr_i[IDX_W+1:2];
    assign i_idx = i_addr_i[IDX_W+1:2];

    // ------------------------------------------------------------------------
    // Arbitration, data port has fixed priority
    // ------------------------------------------------------------------------
    assign d_gnt_o = d_req_i;
    assign i_gnt_o = i_req_i && !d_req_i;

    // One access per cycle on the single port
    assign acc_idx = d_gnt_o ? d_idx : i_idx;
    assign rd_word = mem[acc_idx];

    // Byte-enabled write, the old word is captured alongside
    always_ff @(posedge clk_i) begin
        if (d_gnt_o && d_we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (d_be_i[b]) begin
                    mem[acc_idx][8*b +: 8] <= d_wdata_i[8*b +: 8];
                end
            end
        end
    end

    // Read data registers, no reset on payload
    always_ff @(posedge clk_i) begin
        if (d_gnt_o) begin
            d_rdata_q <= rd_word;
        end
        if (i_gnt_o) begin
            i_rdata_q <= rd_word;
        end
    end

    // rvalid follows the grant by exactly one cycle
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            d_rvalid_q <= 1'b0;
            i_rvalid_q <= 1'b0;
        end else begin
            d_rvalid_q <= d_gnt_o;
            i_rvalid_q <= i_gnt_o;
        end
    end

    assign d_rvalid_o = d_rvalid_q;
    assign d_rdata_o  = d_rdata_q;
    assign i_rvalid_o = i_rvalid_q;
    assign i_rdata_o  = i_rdata_q;

endmodule : obi_sram

//--- src/subsys_pkg.sv
//--------------------------------------------------------------------------
// Register map, fetch FSM states and reset values of the subsystem
//--------------------------------------------------------------------------

package subsys_pkg;

    // Index into the control register block
    typedef logic [1:0] cfg_addr_t;

    // Control register map
    typedef enum logic [1:0] {
        REG_BOOT_ADDR = 2'd0,
        REG_FETCH_EN  = 2'd1,
        REG_MHARTID   = 2'd2,
        REG_ALERT     = 2'd3
    } cfg_reg_e;

    // Instruction fetch controller states
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } fetch_state_e;

    // Reset values
    localparam logic [31:0] BOOT_ADDR_RST = 32'h0000_0080;
    localparam logic        FETCH_EN_RST  = 1'b0;
    localparam logic [31:0] MHARTID_RST   = 32'h0000_0000;
    localparam logic        ALERT_RST     = 1'b0;

endpackage : subsys_pkg
